//--- Makefile
VERILATOR    ?= verilator
TOP          ?= cpu_tb
FILELIST     ?= project.f
BUILD_DIR    ?= obj_dir
RESET_VECTOR ?= 256
SEED         ?= 11
VFLAGS       ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: RESET_VECTOR=$(RESET_VECTOR) SEED=$(SEED) BUILD_DIR=$(BUILD_DIR)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-GRESET_VECTOR=$(RESET_VECTOR) -GSEED=$(SEED) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t sel,
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  logic             carry_in,
    output cpu_pkg::byte_t   result,
    output logic             carry_out
);

    import cpu_pkg::*;

    logic [8:0] wide;   // ninth bit holds the carry or the borrow

    always_comb begin
        wide      = 9'd0;
        result    = b;
        carry_out = carry_in;
        case (sel)
            ALU_ADD: begin
                wide      = {1'b0, a} + {1'b0, b};
                result    = wide[7:0];
                carry_out = wide[8];
            end
            ALU_ADDC: begin
                wide      = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
                result    = wide[7:0];
                carry_out = wide[8];
            end
            ALU_SUBB: begin
                // wraps below zero, so bit 8 is the borrow
                wide      = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
                result    = wide[7:0];
                carry_out = wide[8];
            end
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_INC:  result = a + 8'd1;   // inc and dec leave the carry alone
            ALU_DEC:  result = a - 8'd1;
            default:  result = b;
        endcase
    end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] code_addr_t;
    typedef logic [7:0]  iram_addr_t;

    localparam int IRAM_DEPTH = 256;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes in the standard 8051 encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        OP_NOP         = 8'h00,
        OP_INC_A       = 8'h04,
        OP_DEC_A       = 8'h14,
        OP_ADD_IMM     = 8'h24,
        OP_ADDC_IMM    = 8'h34,
        OP_ORL_IMM     = 8'h44,
        OP_ANL_IMM     = 8'h54,
        OP_XRL_IMM     = 8'h64,
        OP_JZ          = 8'h60,
        OP_JNZ         = 8'h70,
        OP_MOV_A_IMM   = 8'h74,
        OP_SJMP        = 8'h80,
        OP_MOV_DPTR    = 8'h90,   // operand1 is the high byte
        OP_SUBB_IMM    = 8'h94,
        OP_INC_DPTR    = 8'hA3,
        OP_CLR_C       = 8'hC3,
        OP_SETB_C      = 8'hD3,
        OP_MOV_A_DIR   = 8'hE5,
        OP_MOVX_DPTR_A = 8'hF0,
        OP_MOV_DIR_A   = 8'hF5
    } op_t;

    typedef enum logic [3:0] {
        ALU_PASS,   // result is the source byte
        ALU_ADD,
        ALU_ADDC,
        ALU_SUBB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_INC,
        ALU_DEC
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_OPER1,
        ST_OPER2,
        ST_EXEC
    } seq_state_t;

    // anything unknown counts as a one byte nop
    function automatic logic [1:0] instr_length(op_t op);
        case (op)
            OP_ADD_IMM, OP_ADDC_IMM, OP_SUBB_IMM,
            OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM,
            OP_MOV_A_IMM, OP_MOV_A_DIR, OP_MOV_DIR_A,
            OP_SJMP, OP_JZ, OP_JNZ: instr_length = 2'd2;
            OP_MOV_DPTR:            instr_length = 2'd3;
            default:                instr_length = 2'd1;
        endcase
    endfunction

endpackage

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::code_addr_t RESET_VECTOR = 16'h0000
) (
    input  logic                clk,
    input  logic                rst,

    output logic                rom_en,
    output cpu_pkg::code_addr_t rom_addr,
    input  cpu_pkg::byte_t      rom_data,

    output logic                ram_wr_en,
    output cpu_pkg::code_addr_t ram_wr_addr,
    output cpu_pkg::byte_t      ram_wr_data
);

    import cpu_pkg::*;

    op_t     opcode;
    byte_t   operand1;
    byte_t   operand2;
    logic    exec_en;
    logic    acc_zero;
    byte_t   acc;
    logic    carry;
    byte_t   alu_src;
    alu_op_t alu_sel;
    byte_t   alu_result;
    logic    alu_carry;

    fetch_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .acc_zero (acc_zero),
        .rom_data (rom_data),
        .rom_en   (rom_en),
        .rom_addr (rom_addr),
        .opcode   (opcode),
        .operand1 (operand1),
        .operand2 (operand2),
        .exec_en  (exec_en)
    );

    data_path u_dp (
        .clk         (clk),
        .rst         (rst),
        .exec_en     (exec_en),
        .opcode      (opcode),
        .operand1    (operand1),
        .operand2    (operand2),
        .alu_result  (alu_result),
        .alu_carry   (alu_carry),
        .acc         (acc),
        .carry       (carry),
        .alu_src     (alu_src),
        .alu_sel     (alu_sel),
        .acc_zero    (acc_zero),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data)
    );

    alu u_alu (
        .sel       (alu_sel),
        .a         (acc),
        .b         (alu_src),
        .carry_in  (carry),
        .result    (alu_result),
        .carry_out (alu_carry)
    );

endmodule

//--- logic/data_path.sv
`timescale 1ns/1ps

module data_path (
    input  logic                clk,
    input  logic                rst,
    input  logic                exec_en,
    input  cpu_pkg::op_t        opcode,
    input  cpu_pkg::byte_t      operand1,
    input  cpu_pkg::byte_t      operand2,
    input  cpu_pkg::byte_t      alu_result,
    input  logic                alu_carry,
    output cpu_pkg::byte_t      acc,
    output logic                carry,
    output cpu_pkg::byte_t      alu_src,
    output cpu_pkg::alu_op_t    alu_sel,
    output logic                acc_zero,
    output logic                ram_wr_en,
    output cpu_pkg::code_addr_t ram_wr_addr,
    output cpu_pkg::byte_t      ram_wr_data
);

    import cpu_pkg::*;

    byte_t      iram [IRAM_DEPTH];
    iram_addr_t dir_addr;
    code_addr_t dptr;
    logic       acc_write;

    assign dir_addr = operand1;   // direct address byte
    assign alu_src  = (opcode == OP_MOV_A_DIR) ? iram[dir_addr] : operand1;
    assign acc_zero = (acc == 8'h00);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode to alu operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        acc_write = 1'b1;
        case (opcode)
            OP_ADD_IMM:   alu_sel = ALU_ADD;
            OP_ADDC_IMM:  alu_sel = ALU_ADDC;
            OP_SUBB_IMM:  alu_sel = ALU_SUBB;
            OP_ANL_IMM:   alu_sel = ALU_AND;
            OP_ORL_IMM:   alu_sel = ALU_OR;
            OP_XRL_IMM:   alu_sel = ALU_XOR;
            OP_INC_A:     alu_sel = ALU_INC;
            OP_DEC_A:     alu_sel = ALU_DEC;
            OP_MOV_A_IMM,
            OP_MOV_A_DIR: alu_sel = ALU_PASS;
            default: begin
                alu_sel   = ALU_PASS;
                acc_write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc   <= 8'h00;
            carry <= 1'b0;
            dptr  <= 16'h0000;
        end else if (exec_en) begin
            if (acc_write) begin
                acc   <= alu_result;
                carry <= alu_carry;   // logic ops hand the old carry back
            end
            case (opcode)
                OP_CLR_C:    carry <= 1'b0;
                OP_SETB_C:   carry <= 1'b1;
                OP_MOV_DPTR: dptr  <= {operand1, operand2};
                OP_INC_DPTR: dptr  <= dptr + 16'd1;
                default:     ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exec_en && (opcode == OP_MOV_DIR_A)) begin
            iram[dir_addr] <= acc;
        end
    end

    // movx write goes out in the execute cycle itself
    assign ram_wr_en   = exec_en && (opcode == OP_MOVX_DPTR_A);
    assign ram_wr_addr = dptr;
    assign ram_wr_data = acc;

endmodule

//--- logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
    parameter cpu_pkg::code_addr_t RESET_VECTOR = 16'h0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                acc_zero,
    input  cpu_pkg::byte_t      rom_data,
    output logic                rom_en,
    output cpu_pkg::code_addr_t rom_addr,
    output cpu_pkg::op_t        opcode,
    output cpu_pkg::byte_t      operand1,
    output cpu_pkg::byte_t      operand2,
    output logic                exec_en
);

    import cpu_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    code_addr_t pc;          // address of the instruction in flight
    code_addr_t pc_seq;
    code_addr_t pc_next;
    op_t        opcode_q;
    byte_t      operand1_q;
    logic [1:0] length;
    logic       taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the rom answers one cycle late, so the newest byte is still on rom_data
    assign opcode   = (state == ST_OPER1) ? op_t'(rom_data) : opcode_q;
    assign operand1 = (state == ST_OPER2) ? rom_data : operand1_q;
    assign operand2 = (state == ST_EXEC)  ? rom_data : 8'h00;   // only mov dptr has one

    assign length = instr_length(opcode);

    // the cycle that receives the last byte is the execute cycle
    always_comb begin
        case (state)
            ST_OPER1: exec_en = (length == 2'd1);
            ST_OPER2: exec_en = (length == 2'd2);
            ST_EXEC:  exec_en = 1'b1;
            default:  exec_en = 1'b0;
        endcase
    end

    assign rom_en = !exec_en;

    always_comb begin
        case (state)
            ST_OPER1: rom_addr = pc + 16'd1;
            ST_OPER2: rom_addr = pc + 16'd2;
            default:  rom_addr = pc;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (opcode)
            OP_SJMP: taken = 1'b1;
            OP_JZ:   taken = acc_zero;
            OP_JNZ:  taken = !acc_zero;
            default: taken = 1'b0;
        endcase
    end

    assign pc_seq  = pc + {14'd0, length};
    assign pc_next = taken ? pc_seq + {{8{operand1[7]}}, operand1} : pc_seq;

    always_comb begin
        case (state)
            ST_OPCODE: state_next = ST_OPER1;
            ST_OPER1:  state_next = exec_en ? ST_OPCODE : ST_OPER2;
            ST_OPER2:  state_next = exec_en ? ST_OPCODE : ST_EXEC;
            default:   state_next = ST_OPCODE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= ST_OPCODE;
            pc       <= RESET_VECTOR;
            opcode_q <= OP_NOP;
        end else begin
            state <= state_next;
            if (exec_en) begin
                pc <= pc_next;
            end
            if (state == ST_OPER1) begin
                opcode_q <= opcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_OPER2) begin
            operand1_q <= rom_data;   // kept for the third byte cycle
        end
    end

endmodule

//--- project.f
logic/cpu_pkg.sv
logic/alu.sv
logic/data_path.sv
logic/fetch_sequencer.sv
logic/cpu_top.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv

//--- testbench/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
    input logic                clk,
    input logic                rst,
    input logic                rom_en,
    input cpu_pkg::code_addr_t rom_addr,
    input logic                ram_wr_en
);

    // a write belongs to the execute cycle, when the rom port is idle
    wr_in_exec: assert property (@(posedge clk) disable iff (!rst)
        $rose(ram_wr_en) |-> !rom_en)
        else $error("ram_wr_en rose while rom_en was high");

    no_wr_in_reset: assert property (@(posedge clk) !rst |-> !ram_wr_en)
        else $error("ram_wr_en was high during reset");

    fetch_addr_known: assert property (@(posedge clk) disable iff (!rst)
        rom_en |-> !$isunknown(rom_addr))
        else $error("rom_addr was unknown during a fetch");

endmodule

bind cpu_top cpu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .rom_en    (rom_en),
    .rom_addr  (rom_addr),
    .ram_wr_en (ram_wr_en)
);

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb #(
    parameter cpu_pkg::code_addr_t RESET_VECTOR = 16'h0100,
    parameter int                  SEED         = 11
);

    import cpu_pkg::*;

    localparam code_addr_t END_ADDR = 16'hFFF0;   // the last write of every program
    localparam byte_t      END_DATA = 8'h5A;

    logic       clk;
    logic       rst;
    logic       rom_en;
    code_addr_t rom_addr;
    byte_t      rom_data = 8'h00;
    logic       ram_wr_en;
    code_addr_t ram_wr_addr;
    byte_t      ram_wr_data;

    byte_t      rom [65536];
    byte_t      prog [$];
    code_addr_t got_addr [$];
    byte_t      got_data [$];
    code_addr_t exp_addr [$];
    byte_t      exp_data [$];
    byte_t      m_acc;            // reference model of the core state
    logic       m_carry;
    code_addr_t m_dptr;
    byte_t      m_iram [256];
    integer     seed;
    int         errors;
    int         checks;

    cpu_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rom_en) begin
            rom_data <= rom[rom_addr];   // one cycle of read latency
        end
        if (ram_wr_en) begin
            got_addr.push_back(ram_wr_addr);
            got_data.push_back(ram_wr_data);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input code_addr_t got, input code_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program building with a reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic byte_t rand_byte();
        return byte_t'($random(seed));
    endfunction

    task automatic emit(input byte_t b);
        prog.push_back(b);
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic movx();
        emit(OP_MOVX_DPTR_A);
        exp_addr.push_back(m_dptr);
        exp_data.push_back(m_acc);
    endtask

    task automatic mov_a(input byte_t v);
        emit(OP_MOV_A_IMM);
        emit(v);
        m_acc = v;
    endtask

    task automatic mov_dptr(input code_addr_t a);
        emit(OP_MOV_DPTR);
        emit(a[15:8]);
        emit(a[7:0]);
        m_dptr = a;
    endtask

    // one accumulator operation followed by a write of the result
    task automatic alu_step(input op_t op, input byte_t imm);
        logic [8:0] sum;
        logic       cin;
        emit(op);
        if (op != OP_INC_A && op != OP_DEC_A) begin
            emit(imm);
        end
        cin = (op == OP_ADD_IMM) ? 1'b0 : m_carry;
        case (op)
            OP_ADD_IMM, OP_ADDC_IMM: begin
                sum     = {1'b0, m_acc} + {1'b0, imm} + {8'd0, cin};
                m_acc   = sum[7:0];
                m_carry = sum[8];
            end
            OP_SUBB_IMM: begin
                m_carry = ({1'b0, m_acc} < ({1'b0, imm} + {8'd0, cin}));
                m_acc   = m_acc - imm - {7'd0, cin};
            end
            OP_ANL_IMM: m_acc = m_acc & imm;
            OP_ORL_IMM: m_acc = m_acc | imm;
            OP_XRL_IMM: m_acc = m_acc ^ imm;
            OP_INC_A:   m_acc = m_acc + 8'd1;
            OP_DEC_A:   m_acc = m_acc - 8'd1;
            default:    ;
        endcase
        movx();
    endtask

    task automatic dir_move(input op_t op, input byte_t addr);
        emit(op);
        emit(addr);
        if (op == OP_MOV_DIR_A) begin
            m_iram[addr] = m_acc;
        end else begin
            m_acc = m_iram[addr];
        end
    endtask

    // the skipped block writes blk_val, so it only shows up when the branch falls through
    task automatic branch_case(input op_t op, input byte_t blk_val);
        logic taken;
        taken = (op == OP_SJMP) || (op == OP_JZ && m_acc == 8'h00) ||
                (op == OP_JNZ && m_acc != 8'h00);
        emit(op);
        emit(8'h03);
        emit(OP_MOV_A_IMM);
        emit(blk_val);
        if (taken) begin
            emit(OP_MOVX_DPTR_A);
        end else begin
            m_acc = blk_val;
            movx();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // running a program
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_program(input string name);
        logic seen;
        mov_dptr(END_ADDR);
        mov_a(END_DATA);
        movx();
        emit(OP_SJMP);
        emit(8'hFE);   // jump to itself
        for (int i = 0; i < 65536; i++) begin
            rom[code_addr_t'(i)] = i[15:8] ^ i[7:0];
        end
        foreach (prog[k]) begin
            rom[RESET_VECTOR + code_addr_t'(k)] = prog[k];
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        got_addr.delete();
        got_data.delete();
        rst <= 1'b1;
        seen = 1'b0;
        for (int n = 0; n < 10 && !seen; n++) begin
            @(negedge clk);
            seen = rom_en;
        end
        if (seen) begin
            check_addr("rom_addr", rom_addr, RESET_VECTOR);
        end else begin
            errors++;
            $display("%s: rom_en never went high after reset", name);
        end
        seen = 1'b0;
        for (int n = 0; n < 4000 && !seen; n++) begin
            @(negedge clk);
            seen = (got_addr.size() > 0) && (got_addr[$] == END_ADDR);
        end
        if (!seen) begin
            errors++;
            $display("%s: timed out waiting for the final marker write", name);
        end
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("%s: saw %0d external writes but expected %0d", name,
                     got_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            check_addr($sformatf("ram_wr_addr %s #%0d", name, i), got_addr[i], exp_addr[i]);
            check_byte($sformatf("ram_wr_data %s #%0d", name, i), got_data[i], exp_data[i]);
        end
    endtask

    task automatic test_reset();
        new_program();
        emit(OP_NOP);
        emit(8'hA5);   // outside the instruction set
        mov_dptr(16'h0040);
        mov_a(8'h3C);
        movx();
        run_program("reset");
    endtask

    task automatic test_alu_chain();
        new_program();
        mov_dptr(16'h0100);
        mov_a(rand_byte());
        movx();
        alu_step(OP_ADD_IMM, rand_byte());
        alu_step(OP_ANL_IMM, rand_byte());
        alu_step(OP_ORL_IMM, rand_byte());
        alu_step(OP_XRL_IMM, rand_byte());
        alu_step(OP_INC_A, 8'h00);
        alu_step(OP_DEC_A, 8'h00);
        run_program("alu chain");
    endtask

    task automatic test_carry();
        new_program();
        mov_dptr(16'h0200);
        mov_a(8'hF0);
        alu_step(OP_ADD_IMM, 8'h20);
        alu_step(OP_ADDC_IMM, 8'h01);
        emit(OP_SETB_C);
        m_carry = 1'b1;
        mov_a(8'h50);
        alu_step(OP_SUBB_IMM, 8'h10);
        alu_step(OP_SUBB_IMM, 8'h40);
        alu_step(OP_ADDC_IMM, 8'h00);
        emit(OP_CLR_C);
        m_carry = 1'b0;
        alu_step(OP_ADDC_IMM, 8'h01);
        run_program("carry");
    endtask

    task automatic test_iram();
        new_program();
        mov_dptr(16'h0300);
        mov_a(rand_byte());
        dir_move(OP_MOV_DIR_A, 8'h30);
        mov_a(rand_byte());
        dir_move(OP_MOV_DIR_A, 8'h7F);
        mov_a(8'h00);
        dir_move(OP_MOV_A_DIR, 8'h30);
        movx();
        dir_move(OP_MOV_A_DIR, 8'h7F);
        movx();
        run_program("iram");
    endtask

    task automatic test_dptr();
        new_program();
        mov_dptr(16'h12FF);
        mov_a(rand_byte());
        movx();
        emit(OP_INC_DPTR);
        m_dptr = m_dptr + 16'd1;
        movx();
        run_program("dptr");
    endtask

    task automatic test_branches();
        new_program();
        mov_dptr(16'h0400);
        mov_a(8'h00);
        branch_case(OP_JZ, 8'hB1);
        mov_a(8'h11);
        movx();
        branch_case(OP_JZ, 8'h22);
        branch_case(OP_JNZ, 8'hB3);
        mov_a(8'h33);
        movx();
        mov_a(8'h00);
        branch_case(OP_JNZ, 8'h44);
        branch_case(OP_SJMP, 8'hB5);
        mov_a(8'h55);
        movx();
        run_program("branches");
    endtask

    initial begin
        rst    = 1'b0;
        seed   = SEED;
        errors = 0;
        checks = 0;
        test_reset();
        test_alu_chain();
        test_carry();
        test_iram();
        test_dptr();
        test_branches();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
